// ==== src/datapathPkg.sv ====
package datapathPkg;

    // Bus, register and index widths
    localparam int dataWidth   = 32;
    localparam int regCount    = 16;
    localparam int regIdxWidth = 4;
    localparam int opWidth     = 5;

    // Derived field widths
    localparam int constWidth  = dataWidth - opWidth - 2 * regIdxWidth;  // 19-bit immediate
    localparam int shiftWidth  = $clog2(dataWidth);                      // Shift amount from B

    // ALU operation codes, shared with the IR opcode field
    localparam logic [opWidth-1:0] opAdd  = 5'b00010;
    localparam logic [opWidth-1:0] opSub  = 5'b00011;
    localparam logic [opWidth-1:0] opAnd  = 5'b00100;
    localparam logic [opWidth-1:0] opOr   = 5'b00101;
    localparam logic [opWidth-1:0] opShr  = 5'b00110;
    localparam logic [opWidth-1:0] opShra = 5'b00111;
    localparam logic [opWidth-1:0] opShl  = 5'b01000;
    localparam logic [opWidth-1:0] opRor  = 5'b01001;
    localparam logic [opWidth-1:0] opRol  = 5'b01010;
    localparam logic [opWidth-1:0] opMul  = 5'b01011;
    localparam logic [opWidth-1:0] opNeg  = 5'b01100;
    localparam logic [opWidth-1:0] opNot  = 5'b01101;

    // Three-register format: op ra, rb, rc
    typedef struct packed {
        logic [opWidth-1:0]                        opcode;
        logic [regIdxWidth-1:0]                    ra;
        logic [regIdxWidth-1:0]                    rb;
        logic [regIdxWidth-1:0]                    rc;
        logic [dataWidth-opWidth-3*regIdxWidth-1:0] unused;  // Ignored by the datapath
    } irRFormat;

    // Register-plus-constant format: op ra, rb, C
    typedef struct packed {
        logic [opWidth-1:0]     opcode;
        logic [regIdxWidth-1:0] ra;
        logic [regIdxWidth-1:0] rb;
        logic [constWidth-1:0]  constant;   // Two's complement
    } irIFormat;

    // Same IR word seen through either format
    typedef union packed {
        irRFormat rFormat;
        irIFormat iFormat;
    } irWord;

endpackage

// ==== src/selectEncode.sv ====
`timescale 1ns/1ps

module selectEncode (
    input  datapathPkg::irWord                    ir,
    input  logic                                  Gra,
    input  logic                                  Grb,
    input  logic                                  Grc,
    input  logic                                  Rin,
    input  logic                                  Rout,
    input  logic                                  BAout,
    output logic [datapathPkg::regCount-1:0]      regWrite,
    output logic [datapathPkg::regIdxWidth-1:0]   readIdx,
    output logic                                  regRead,
    output logic                                  baseRead,
    output logic [datapathPkg::dataWidth-1:0]     constExt
);
    import datapathPkg::*;

    logic [regIdxWidth-1:0] selIdx;
    logic                   constSign;

    // The three group selects pick one IR register field
    always_comb begin
        selIdx = '0;
        if (Gra) begin
            selIdx = selIdx | ir.rFormat.ra;
        end
        if (Grb) begin
            selIdx = selIdx | ir.rFormat.rb;
        end
        if (Grc) begin
            selIdx = selIdx | ir.rFormat.rc;
        end
    end

    // One-hot write strobe for the selected register
    always_comb begin
        regWrite = '0;
        if (Rin) begin
            regWrite[selIdx] = 1'b1;
        end
    end

    assign readIdx  = selIdx;
    assign regRead  = Rout | BAout;   // Either read form drives the bus
    assign baseRead = BAout;

    // Immediate sign-extended to a full word
    assign constSign = ir.iFormat.constant[constWidth-1];
    assign constExt  = {{(dataWidth - constWidth){constSign}}, ir.iFormat.constant};

endmodule

// ==== src/registerFile.sv ====
`timescale 1ns/1ps

module registerFile (
    input  logic                                  Clock,
    input  logic                                  rstN,
    input  logic                                  stepEn,
    input  logic [datapathPkg::regCount-1:0]      regWrite,
    input  logic [datapathPkg::regIdxWidth-1:0]   readIdx,
    input  logic                                  baseRead,
    input  logic [datapathPkg::dataWidth-1:0]     writeData,
    output logic [datapathPkg::dataWidth-1:0]     readData
);
    import datapathPkg::*;

    logic [dataWidth-1:0] regs [regCount];
    logic                 zeroBase;

    // R0..R15, each with its own write strobe
    for (genvar i = 0; i < regCount; i++) begin : gReg
        always_ff @(posedge Clock) begin
            if (!rstN) begin
                regs[i] <= '0;
            end else if (stepEn && regWrite[i]) begin
                regs[i] <= writeData;
            end
        end
    end

    // Base addressing treats R0 as "no base register"
    assign zeroBase = baseRead && (readIdx == '0);

    always_comb begin
        if (zeroBase) begin
            readData = '0;
        end else begin
            readData = regs[readIdx];
        end
    end

endmodule

// ==== src/aluUnit.sv ====
`timescale 1ns/1ps

module aluUnit (
    input  logic [datapathPkg::dataWidth-1:0]     opA,
    input  logic [datapathPkg::dataWidth-1:0]     opB,
    input  logic [datapathPkg::opWidth-1:0]       aluOp,
    input  logic                                  incB,
    output logic [2*datapathPkg::dataWidth-1:0]   result
);
    import datapathPkg::*;

    logic [shiftWidth-1:0]         shAmt;
    logic [2*dataWidth-1:0]        rotRight;
    logic [2*dataWidth-1:0]        rotLeft;
    logic signed [2*dataWidth-1:0] product;
    logic [dataWidth-1:0]          lowWord;

    assign shAmt = opB[shiftWidth-1:0];   // Only the low bits of B count

    // Rotates built from a doubled copy of A
    assign rotRight = {opA, opA} >> shAmt;
    assign rotLeft  = {opA, opA} << shAmt;

    // Full signed product, both halves kept
    assign product = $signed(opA) * $signed(opB);

    // Single-word operations
    always_comb begin
        lowWord = '0;
        if (incB) begin
            lowWord = opB + 1'b1;   // PC increment path
        end else begin
            case (aluOp)
                opAdd:   lowWord = opA + opB;
                opSub:   lowWord = opA - opB;
                opAnd:   lowWord = opA & opB;
                opOr:    lowWord = opA | opB;
                opShr:   lowWord = opA >> shAmt;
                opShra:  lowWord = $signed(opA) >>> shAmt;
                opShl:   lowWord = opA << shAmt;
                opRor:   lowWord = rotRight[dataWidth-1:0];
                opRol:   lowWord = rotLeft[2*dataWidth-1:dataWidth];
                opNeg:   lowWord = -opB;
                opNot:   lowWord = ~opB;
                default: lowWord = '0;
            endcase
        end
    end

    // Only multiply fills the upper word
    always_comb begin
        if (!incB && aluOp == opMul) begin
            result = product;
        end else begin
            result = {{dataWidth{1'b0}}, lowWord};
        end
    end

endmodule

// ==== src/busDatapath.sv ====
`timescale 1ns/1ps

module busDatapath (
    input  logic                                  Clock,
    input  logic                                  rstN,
    input  logic                                  stepReq,
    output logic                                  stepAck,
    input  logic                                  PCout,
    input  logic                                  PCin,
    input  logic                                  IncPC,
    input  logic                                  MARin,
    input  logic                                  MDRin,
    input  logic                                  MDRout,
    input  logic                                  Read,
    input  logic                                  IRin,
    input  logic                                  Yin,
    input  logic                                  Zin,
    input  logic                                  Zhighout,
    input  logic                                  Zlowout,
    input  logic                                  HIin,
    input  logic                                  HIout,
    input  logic                                  LOin,
    input  logic                                  LOout,
    input  logic                                  Gra,
    input  logic                                  Grb,
    input  logic                                  Grc,
    input  logic                                  Rin,
    input  logic                                  Rout,
    input  logic                                  BAout,
    input  logic                                  Cout,
    input  logic [datapathPkg::opWidth-1:0]       aluOp,
    input  logic [datapathPkg::dataWidth-1:0]     memDataIn,
    output logic [datapathPkg::dataWidth-1:0]     memDataOut,
    output logic [datapathPkg::dataWidth-1:0]     memAddr
);
    import datapathPkg::*;

    logic                   stepEn;
    logic [dataWidth-1:0]   busData;

    // Special registers
    logic [dataWidth-1:0]   pcReg;
    irWord                  irReg;
    logic [dataWidth-1:0]   marReg;
    logic [dataWidth-1:0]   mdrReg;
    logic [dataWidth-1:0]   yReg;
    logic [2*dataWidth-1:0] zReg;
    logic [dataWidth-1:0]   hiReg;
    logic [dataWidth-1:0]   loReg;

    // Select-and-encode and register file wiring
    logic [regCount-1:0]    regWrite;
    logic [regIdxWidth-1:0] readIdx;
    logic                   regRead;
    logic                   baseRead;
    logic [dataWidth-1:0]   constExt;
    logic [dataWidth-1:0]   regData;
    logic [2*dataWidth-1:0] aluResult;

    // New request not yet acknowledged, so exactly one edge per step
    assign stepEn = stepReq && !stepAck;

    always_ff @(posedge Clock) begin
        if (!rstN) begin
            stepAck <= 1'b0;
        end else if (stepEn) begin
            stepAck <= 1'b1;
        end else if (!stepReq) begin
            stepAck <= 1'b0;   // Controller finished the handshake
        end
    end

    selectEncode uSelect (
        .ir       (irReg),
        .Gra      (Gra),
        .Grb      (Grb),
        .Grc      (Grc),
        .Rin      (Rin),
        .Rout     (Rout),
        .BAout    (BAout),
        .regWrite (regWrite),
        .readIdx  (readIdx),
        .regRead  (regRead),
        .baseRead (baseRead),
        .constExt (constExt)
    );

    registerFile uRegs (
        .Clock     (Clock),
        .rstN      (rstN),
        .stepEn    (stepEn),
        .regWrite  (regWrite),
        .readIdx   (readIdx),
        .baseRead  (baseRead),
        .writeData (busData),
        .readData  (regData)
    );

    // Y is operand A, the bus is operand B
    aluUnit uAlu (
        .opA    (yReg),
        .opB    (busData),
        .aluOp  (aluOp),
        .incB   (IncPC),
        .result (aluResult)
    );

    // Bus source mux, one out-control per step
    always_comb begin
        if (PCout)         busData = pcReg;
        else if (MDRout)   busData = mdrReg;
        else if (Zhighout) busData = zReg[2*dataWidth-1:dataWidth];
        else if (Zlowout)  busData = zReg[dataWidth-1:0];
        else if (HIout)    busData = hiReg;
        else if (LOout)    busData = loReg;
        else if (regRead)  busData = regData;
        else if (Cout)     busData = constExt;
        else               busData = '0;
    end

    // Load enables take effect only on the step edge
    always_ff @(posedge Clock) begin
        if (!rstN) begin
            pcReg  <= '0;
            irReg  <= '0;
            marReg <= '0;
            mdrReg <= '0;
            yReg   <= '0;
            zReg   <= '0;
            hiReg  <= '0;
            loReg  <= '0;
        end else if (stepEn) begin
            if (PCin)  pcReg  <= busData;
            if (IRin)  irReg  <= busData;
            if (MARin) marReg <= busData;
            if (MDRin) mdrReg <= Read ? memDataIn : busData;   // Memory read or bus
            if (Yin)   yReg   <= busData;
            if (Zin)   zReg   <= aluResult;
            if (HIin)  hiReg  <= busData;
            if (LOin)  loReg  <= busData;
        end
    end

    assign memDataOut = mdrReg;
    assign memAddr    = marReg;

endmodule

// ==== verif/busDatapath_props.sv ====
`timescale 1ns/1ps

module busDatapathProps (
    input logic Clock,
    input logic rstN,
    input logic stepReq,
    input logic stepAck,
    input logic PCout,
    input logic MDRout,
    input logic Zhighout,
    input logic Zlowout,
    input logic HIout,
    input logic LOout,
    input logic Rout,
    input logic BAout,
    input logic Cout
);

    ackLowInReset: assert property (@(posedge Clock) !rstN |=> !stepAck)
        else $error("stepAck high after a reset cycle");

    // Rise needs a pending request, fall needs a released one
    ackRiseOnReq: assert property (@(posedge Clock) disable iff (!rstN)
        $rose(stepAck) |-> $past(stepReq))
        else $error("stepAck rose without stepReq");

    ackFallAfterRelease: assert property (@(posedge Clock) disable iff (!rstN)
        $fell(stepAck) |-> !$past(stepReq))
        else $error("stepAck fell while stepReq was still high");

    oneBusSource: assert property (@(posedge Clock) disable iff (!rstN)
        (stepReq && !stepAck) |->
            $onehot0({PCout, MDRout, Zhighout, Zlowout, HIout, LOout, Rout, BAout, Cout}))
        else $error("More than one bus source active in a step");

endmodule

bind busDatapath busDatapathProps uProps (
    .Clock    (Clock),
    .rstN     (rstN),
    .stepReq  (stepReq),
    .stepAck  (stepAck),
    .PCout    (PCout),
    .MDRout   (MDRout),
    .Zhighout (Zhighout),
    .Zlowout  (Zlowout),
    .HIout    (HIout),
    .LOout    (LOout),
    .Rout     (Rout),
    .BAout    (BAout),
    .Cout     (Cout)
);

// ==== verif/datapathTb.sv ====
`timescale 1ns/1ps

module datapathTb;
    import datapathPkg::*;

    localparam int maxRows = 128;
    localparam int selNone = 0;
    localparam int selData = 1;   // Compare memDataOut
    localparam int selAddr = 2;   // Compare memAddr

    // Control word bits, in the order of the DUT ports below
    localparam logic [22:0] ctlPCout    = 23'd1 << 0;
    localparam logic [22:0] ctlPCin     = 23'd1 << 1;
    localparam logic [22:0] ctlIncPC    = 23'd1 << 2;
    localparam logic [22:0] ctlMARin    = 23'd1 << 3;
    localparam logic [22:0] ctlMDRin    = 23'd1 << 4;
    localparam logic [22:0] ctlMDRout   = 23'd1 << 5;
    localparam logic [22:0] ctlRead     = 23'd1 << 6;
    localparam logic [22:0] ctlIRin     = 23'd1 << 7;
    localparam logic [22:0] ctlYin      = 23'd1 << 8;
    localparam logic [22:0] ctlZin      = 23'd1 << 9;
    localparam logic [22:0] ctlZhighout = 23'd1 << 10;
    localparam logic [22:0] ctlZlowout  = 23'd1 << 11;
    localparam logic [22:0] ctlHIin     = 23'd1 << 12;
    localparam logic [22:0] ctlHIout    = 23'd1 << 13;
    localparam logic [22:0] ctlLOin     = 23'd1 << 14;
    localparam logic [22:0] ctlLOout    = 23'd1 << 15;
    localparam logic [22:0] ctlGra      = 23'd1 << 16;
    localparam logic [22:0] ctlGrb      = 23'd1 << 17;
    localparam logic [22:0] ctlGrc      = 23'd1 << 18;
    localparam logic [22:0] ctlRin      = 23'd1 << 19;
    localparam logic [22:0] ctlRout     = 23'd1 << 20;
    localparam logic [22:0] ctlBAout    = 23'd1 << 21;
    localparam logic [22:0] ctlCout     = 23'd1 << 22;

    logic                 Clock = 1'b0;
    logic                 rstN;
    logic                 stepReq;
    logic                 stepAck;
    logic [22:0]          ctrl;
    logic [opWidth-1:0]   aluOp;
    logic [dataWidth-1:0] memDataIn;
    logic [dataWidth-1:0] memDataOut;
    logic [dataWidth-1:0] memAddr;

    // Stimulus table
    logic [22:0]          ctrlTab [maxRows];
    logic [opWidth-1:0]   opTab   [maxRows];
    logic [dataWidth-1:0] memTab  [maxRows];
    int                   selTab  [maxRows];
    logic [dataWidth-1:0] expTab  [maxRows];
    int                   rowCount = 0;

    logic [opWidth-1:0] opList [11] = '{opAdd, opSub, opAnd, opOr, opShr, opShra,
                                        opShl, opRor, opRol, opNeg, opNot};
    integer seed = 32'h4e551a46;
    int     errorCount = 0;
    int     checkCount = 0;
    int     cycleCount = 0;
    int     cycleLimit = 100000;   // Replaced once the table length is known

    always #20 Clock = ~Clock;

    busDatapath u_dut (
        .Clock      (Clock),
        .rstN       (rstN),
        .stepReq    (stepReq),
        .stepAck    (stepAck),
        .PCout      (ctrl[0]),
        .PCin       (ctrl[1]),
        .IncPC      (ctrl[2]),
        .MARin      (ctrl[3]),
        .MDRin      (ctrl[4]),
        .MDRout     (ctrl[5]),
        .Read       (ctrl[6]),
        .IRin       (ctrl[7]),
        .Yin        (ctrl[8]),
        .Zin        (ctrl[9]),
        .Zhighout   (ctrl[10]),
        .Zlowout    (ctrl[11]),
        .HIin       (ctrl[12]),
        .HIout      (ctrl[13]),
        .LOin       (ctrl[14]),
        .LOout      (ctrl[15]),
        .Gra        (ctrl[16]),
        .Grb        (ctrl[17]),
        .Grc        (ctrl[18]),
        .Rin        (ctrl[19]),
        .Rout       (ctrl[20]),
        .BAout      (ctrl[21]),
        .Cout       (ctrl[22]),
        .aluOp      (aluOp),
        .memDataIn  (memDataIn),
        .memDataOut (memDataOut),
        .memAddr    (memAddr)
    );

    // Expected single-word ALU results, written from the operation rules
    function automatic logic [31:0] refAlu(input logic [4:0] op, input logic [31:0] a, b);
        logic [4:0] s;
        s = b[4:0];
        case (op)
            opAdd:   return a + b;
            opSub:   return a - b;
            opAnd:   return a & b;
            opOr:    return a | b;
            opShr:   return a >> s;
            opShra:  return $signed(a) >>> s;
            opShl:   return a << s;
            opRor:   return (a >> s) | (a << (6'd32 - s));   // Shift by 32 gives 0
            opRol:   return (a << s) | (a >> (6'd32 - s));
            opNeg:   return 32'd0 - b;
            opNot:   return ~b;
            default: return '0;
        endcase
    endfunction

    function automatic irWord rWord(input logic [4:0] op, input logic [3:0] ra, rb, rc);
        irWord w;
        w = '0;
        w.rFormat.opcode = op;
        w.rFormat.ra = ra;
        w.rFormat.rb = rb;
        w.rFormat.rc = rc;
        return w;
    endfunction

    function automatic irWord iWord(input logic [4:0] op, input logic [3:0] ra, rb, input int c);
        irWord w;
        w = '0;
        w.iFormat.opcode = op;
        w.iFormat.ra = ra;
        w.iFormat.rb = rb;
        w.iFormat.constant = c[18:0];
        return w;
    endfunction

    task automatic addRow(input logic [22:0] ctl, input logic [4:0] op,
                          input logic [31:0] mem, input int sel, input logic [31:0] expVal);
        ctrlTab[rowCount] = ctl;
        opTab[rowCount]   = op;
        memTab[rowCount]  = mem;
        selTab[rowCount]  = sel;
        expTab[rowCount]  = expVal;
        rowCount++;
    endtask

    task automatic memToMdr(input logic [31:0] value);
        addRow(ctlRead | ctlMDRin, opAdd, value, selNone, '0);
    endtask

    task automatic loadIr(input irWord w);
        memToMdr(w);
        addRow(ctlMDRout | ctlIRin, opAdd, '0, selNone, '0);
    endtask

    // Leaves IR with ra pointing at the loaded register
    task automatic loadReg(input logic [3:0] idx, input logic [31:0] value);
        loadIr(rWord(opAdd, idx, 4'd0, 4'd0));
        memToMdr(value);
        addRow(ctlMDRout | ctlGra | ctlRin, opAdd, '0, selNone, '0);
    endtask

    // Y gets a, the bus carries b, the low Z word lands in MDR
    task automatic aluRows(input logic [4:0] op, input logic [31:0] a, b);
        memToMdr(a);
        addRow(ctlMDRout | ctlYin, opAdd, '0, selNone, '0);
        memToMdr(b);
        addRow(ctlMDRout | ctlZin, op, '0, selNone, '0);
        addRow(ctlZlowout | ctlMDRin, opAdd, '0, selData, refAlu(op, a, b));
    endtask

    task automatic buildTable();
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] base;
        logic [31:0] cExt;
        logic [31:0] pcModel;
        longint      prod;
        int          cVal;

        // Memory load path and a register round trip
        a = $random(seed);
        loadIr(rWord(opAdd, 4'd4, 4'd0, 4'd0));
        addRow(ctlRead | ctlMDRin, opAdd, a, selData, a);
        addRow(ctlMDRout | ctlGra | ctlRin, opAdd, '0, selNone, '0);
        addRow(ctlRead | ctlMDRin, opAdd, ~a, selData, ~a);   // Overwrite MDR
        addRow(ctlGra | ctlRout | ctlMDRin, opAdd, '0, selData, a);

        // add R1, R2, R3 with -5 + 6
        loadReg(4'd2, -32'sd5);
        loadReg(4'd3, 32'd6);
        loadIr(rWord(opAdd, 4'd1, 4'd2, 4'd3));
        addRow(ctlGrb | ctlRout | ctlYin, opAdd, '0, selNone, '0);
        addRow(ctlGrc | ctlRout | ctlZin, opAdd, '0, selNone, '0);
        addRow(ctlZlowout | ctlGra | ctlRin, opAdd, '0, selNone, '0);
        addRow(ctlGra | ctlRout | ctlMDRin, opAdd, '0, selData, 32'd1);

        // Two fetch increments from a random PC, MAR still holds its reset value
        pcModel = $random(seed);
        memToMdr(pcModel);
        addRow(ctlMDRout | ctlPCin, opAdd, '0, selNone, '0);
        for (int i = 0; i < 2; i++) begin
            addRow(ctlPCout | ctlMARin | ctlIncPC | ctlZin, opAdd, '0, selAddr, pcModel);
            addRow(ctlZlowout | ctlPCin, opAdd, '0, selNone, '0);
            pcModel = pcModel + 32'd1;
            addRow(ctlPCout | ctlMARin, opAdd, '0, selAddr, pcModel);
        end

        foreach (opList[i]) begin
            a = $random(seed);
            b = $random(seed);
            aluRows(opList[i], a, b);
        end

        // Signed multiply through HI and LO
        for (int i = 0; i < 2; i++) begin
            a = $random(seed);
            b = $random(seed);
            prod = longint'($signed(a)) * longint'($signed(b));
            memToMdr(a);
            addRow(ctlMDRout | ctlYin, opAdd, '0, selNone, '0);
            memToMdr(b);
            addRow(ctlMDRout | ctlZin, opMul, '0, selNone, '0);
            addRow(ctlZhighout | ctlHIin, opAdd, '0, selNone, '0);
            addRow(ctlZlowout | ctlLOin, opAdd, '0, selNone, '0);
            addRow(ctlHIout | ctlMDRin, opAdd, '0, selData, prod[63:32]);
            addRow(ctlLOout | ctlMDRin, opAdd, '0, selData, prod[31:0]);
        end

        // R0 holds a nonzero value, base addressing must still read it as zero
        base = $random(seed) | 32'd1;
        loadReg(4'd0, base);

        // Constant with R0 as base, then with R6 as base
        cVal = -1000;
        cExt = cVal;
        loadIr(iWord(opAdd, 4'd5, 4'd0, cVal));
        addRow(ctlBAout | ctlGrb | ctlYin, opAdd, '0, selNone, '0);
        addRow(ctlCout | ctlZin, opAdd, '0, selNone, '0);
        addRow(ctlZlowout | ctlMARin, opAdd, '0, selAddr, cExt);
        base = $random(seed);
        cVal = -4660;
        cExt = cVal;
        loadReg(4'd6, base);
        loadIr(iWord(opAdd, 4'd5, 4'd6, cVal));
        addRow(ctlBAout | ctlGrb | ctlYin, opAdd, '0, selNone, '0);
        addRow(ctlCout | ctlZin, opAdd, '0, selNone, '0);
        addRow(ctlZlowout | ctlMARin, opAdd, '0, selAddr, base + cExt);
    endtask

    // Full four-phase transaction for one control word
    task automatic runStep(input logic [22:0] ctl, input logic [4:0] op, input logic [31:0] mem);
        @(posedge Clock);
        ctrl      <= ctl;
        aluOp     <= op;
        memDataIn <= mem;
        stepReq   <= 1'b1;
        @(negedge Clock);
        while (!stepAck) begin
            @(negedge Clock);
        end
        @(posedge Clock);
        stepReq <= 1'b0;
        ctrl    <= '0;
        @(negedge Clock);
        while (stepAck) begin
            @(negedge Clock);
        end
    endtask

    task automatic checkValue(input string name, input logic [31:0] actual, expected);
        checkCount++;
        if (actual !== expected) begin
            $display("[FAIL] t=%0t %s: got %h, expected %h", $time, name, actual, expected);
            errorCount++;
        end
    endtask

    task automatic finishRun();
        $display("Checks: %0d, errors: %0d", checkCount, errorCount);
        if (errorCount == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    endtask

    always @(posedge Clock) begin
        cycleCount <= cycleCount + 1;
        if (cycleCount >= cycleLimit) begin
            $display("Timeout: run did not finish within %0d cycles", cycleLimit);
            errorCount++;
            finishRun();
        end
    end

    initial begin
        rstN      = 1'b0;
        stepReq   = 1'b0;
        ctrl      = '0;
        aluOp     = '0;
        memDataIn = '0;
        buildTable();
        cycleLimit = 8 * rowCount + 20;
        repeat (4) @(posedge Clock);
        rstN <= 1'b1;
        for (int i = 0; i < rowCount; i++) begin
            runStep(ctrlTab[i], opTab[i], memTab[i]);
            if (selTab[i] == selData) begin
                checkValue("memDataOut", memDataOut, expTab[i]);
            end else if (selTab[i] == selAddr) begin
                checkValue("memAddr", memAddr, expTab[i]);
            end
        end
        finishRun();
    end

endmodule

// ==== src.f ====
src/datapathPkg.sv
src/selectEncode.sv
src/registerFile.sv
src/aluUnit.sv
src/busDatapath.sv
verif/busDatapath_props.sv
verif/datapathTb.sv

// ==== Makefile ====
SIM      = verilator
FLAGS    = --binary --timing --assert
TOP      = datapathTb
FILELIST = src.f
OBJDIR   = obj_dir
LOG      = sim.log
FAILMSG  = Test FAILED

.PHONY: all compile run clean

all: run

compile:
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)

run: compile
	./$(OBJDIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "$(FAILMSG)" $(LOG); then \
	    echo "Simulation failed, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(OBJDIR) $(LOG)
